// File: verilog/dcache_pkg.sv
package dcache_pkg;

	// width of a word address in bits
	localparam int ADDR_W = 16;
	localparam int NUM_SETS = 32;

	typedef logic [15:0] word_t;

	// word 0 sits in the low bits of the line
	typedef word_t [3:0] line_t;

	typedef logic [8:0] tag_t;
	typedef logic [4:0] index_t;
	typedef logic [1:0] offset_t;

	// cache view of a line address
	typedef struct packed {
		tag_t tag;
		index_t index;
	} line_addr_s;

	// memory reads the flat form and the cache reads tag and index
	typedef union packed {
		logic [13:0] flat;
		line_addr_s f;
	} line_addr_u;

endpackage

// File: verilog/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
	import dcache_pkg::*;

	// request levels held until rdy returns high
	logic o_re;
	logic o_we;
	line_addr_u addr;
	line_t wdata;

	// memory side
	line_t rdata;
	logic rdy;

	modport ctrl (
		output o_re,
		output o_we,
		output addr,
		output wdata,
		input rdata,
		input rdy
	);

	modport mem (
		input o_re,
		input o_we,
		input addr,
		input wdata,
		output rdata,
		output rdy
	);

endinterface

// File: verilog/dcache_ways.sv
`timescale 1ns/1ps

module dcache_ways (
	input logic clk,
	input logic rst,
	input dcache_pkg::index_t i_index,
	input logic i_way_we,
	input logic i_way_sel,
	input logic i_valid,
	input logic i_dirty,
	input dcache_pkg::tag_t i_tag,
	input dcache_pkg::line_t i_line,
	input logic i_lru_we,
	input logic i_lru,
	output logic o_valid0,
	output logic o_dirty0,
	output dcache_pkg::tag_t o_tag0,
	output dcache_pkg::line_t o_line0,
	output logic o_valid1,
	output logic o_dirty1,
	output dcache_pkg::tag_t o_tag1,
	output dcache_pkg::line_t o_line1,
	output logic o_lru
);
	import dcache_pkg::*;

	// bit [w] of each entry belongs to way w
	logic [1:0] valid_q [NUM_SETS];
	logic [1:0] dirty_q [NUM_SETS];
	tag_t tag_q [NUM_SETS][2];
	line_t line_q [NUM_SETS][2];

	// lru bit names the way to replace next
	logic [NUM_SETS-1:0] lru_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
			lru_q <= '0;
		end else begin
			if (i_way_we) begin
				valid_q[i_index][i_way_sel] <= i_valid;
				dirty_q[i_index][i_way_sel] <= i_dirty;
			end
			if (i_lru_we) begin
				lru_q[i_index] <= i_lru;
			end
		end
	end

	// tag and data payload
	always_ff @(posedge clk) begin
		if (i_way_we) begin
			tag_q[i_index][i_way_sel] <= i_tag;
			line_q[i_index][i_way_sel] <= i_line;
		end
	end

	// zero-latency reads of the indexed set
	assign o_valid0 = valid_q[i_index][0];
	assign o_dirty0 = dirty_q[i_index][0];
	assign o_tag0 = tag_q[i_index][0];
	assign o_line0 = line_q[i_index][0];
	assign o_valid1 = valid_q[i_index][1];
	assign o_dirty1 = dirty_q[i_index][1];
	assign o_tag1 = tag_q[i_index][1];
	assign o_line1 = line_q[i_index][1];
	assign o_lru = lru_q[i_index];

	// an unknown way select would corrupt both ways of the set
	a_way_sel_known: assert property (@(posedge clk) disable iff (rst)
		i_way_we |-> !$isunknown(i_way_sel))
		else $error("way write with unknown way select");

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
	input logic clk,
	input logic rst,
	input logic [dcache_pkg::ADDR_W-1:0] i_addr,
	input logic i_re,
	input logic i_we,
	input dcache_pkg::word_t i_wdata,
	output dcache_pkg::word_t o_rdata,
	output logic o_hit,
	output dcache_pkg::index_t o_index,
	output logic o_way_we,
	output logic o_way_sel,
	output logic o_valid,
	output logic o_dirty,
	output dcache_pkg::tag_t o_tag,
	output dcache_pkg::line_t o_line,
	output logic o_lru_we,
	output logic o_lru,
	input logic i_valid0,
	input logic i_dirty0,
	input dcache_pkg::tag_t i_tag0,
	input dcache_pkg::line_t i_line0,
	input logic i_valid1,
	input logic i_dirty1,
	input dcache_pkg::tag_t i_tag1,
	input dcache_pkg::line_t i_line1,
	input logic i_lru,
	mem_bus_if.ctrl bus
);
	import dcache_pkg::*;

	typedef enum logic [1:0] {
		ST_NORMAL,
		ST_EVICT,
		ST_FETCH,
		ST_SPIN
	} state_t;

	state_t state, next_state;

	line_addr_u req_la;
	line_addr_u vic_la;
	offset_t off;
	logic req;
	logic hit0, hit1, hit, hit_way;
	line_t hit_line;
	line_t merge_line;
	logic vic_way;
	logic vic_dirty;
	tag_t vic_tag;
	line_t vic_line;

	// split the request address
	assign req_la = i_addr[ADDR_W-1:2];
	assign off = i_addr[1:0];
	assign o_index = req_la.f.index;
	assign req = i_re || i_we;

	// tag compare against both ways
	assign hit0 = i_valid0 && (i_tag0 == req_la.f.tag);
	assign hit1 = i_valid1 && (i_tag1 == req_la.f.tag);
	assign hit = hit0 || hit1;
	assign hit_way = hit1;
	assign hit_line = hit_way ? i_line1 : i_line0;

	// read word and write merge
	assign o_rdata = hit_line[off];

	always_comb begin
		merge_line = hit_line;
		merge_line[off] = i_wdata;
	end

	// fill an empty way first, else replace the lru way
	assign vic_way = !i_valid0 ? 1'b0 : (!i_valid1 ? 1'b1 : i_lru);
	assign vic_dirty = vic_way ? (i_valid1 && i_dirty1) : (i_valid0 && i_dirty0);
	assign vic_tag = vic_way ? i_tag1 : i_tag0;
	assign vic_line = vic_way ? i_line1 : i_line0;

	always_comb begin
		vic_la.f.tag = vic_tag;
		vic_la.f.index = req_la.f.index;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_NORMAL;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		o_hit = 1'b0;
		o_way_we = 1'b0;
		o_way_sel = hit_way;
		o_valid = 1'b1;
		o_dirty = 1'b1;
		o_tag = req_la.f.tag;
		o_line = merge_line;
		o_lru_we = 1'b0;
		o_lru = ~hit_way;
		bus.o_re = 1'b0;
		bus.o_we = 1'b0;
		bus.addr = req_la;
		bus.wdata = vic_line;

		case (state)
			ST_NORMAL: begin
				if (!req) begin
					o_hit = 1'b1;
				end else if (hit) begin
					o_hit = 1'b1;
					o_lru_we = 1'b1;
					// write hit stores the merged line dirty, then spins
					if (i_we) begin
						o_way_we = 1'b1;
						next_state = ST_SPIN;
					end
				end else if (vic_dirty) begin
					bus.o_we = 1'b1;
					bus.addr = vic_la;
					next_state = ST_EVICT;
				end else begin
					bus.o_re = 1'b1;
					next_state = ST_FETCH;
				end
			end

			// write the dirty victim back
			ST_EVICT: begin
				if (!bus.rdy) begin
					bus.o_we = 1'b1;
					bus.addr = vic_la;
				end else begin
					bus.o_re = 1'b1;
					next_state = ST_FETCH;
				end
			end

			// read the missing line and install it clean
			ST_FETCH: begin
				if (!bus.rdy) begin
					bus.o_re = 1'b1;
				end else begin
					o_way_we = 1'b1;
					o_way_sel = vic_way;
					o_dirty = 1'b0;
					o_line = bus.rdata;
					o_lru_we = 1'b1;
					o_lru = ~vic_way;
					next_state = ST_NORMAL;
				end
			end

			default: begin
				next_state = ST_NORMAL;
			end
		endcase
	end

	a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(bus.o_re && bus.o_we))
		else $error("memory read and write requested together");

	// memory samples the address over the whole access
	a_addr_stable: assert property (@(posedge clk) disable iff (rst)
		!bus.rdy |-> $stable(bus.addr))
		else $error("memory address changed while busy");

endmodule

// File: verilog/main_mem.sv
`timescale 1ns/1ps

module main_mem #(
	parameter int MEM_LATENCY = 4
) (
	input logic clk,
	input logic rst,
	mem_bus_if.mem bus
);
	import dcache_pkg::*;

	localparam int NUM_LINES = 2 ** 14;
	localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

	typedef enum logic {
		MEM_IDLE,
		MEM_COUNT
	} mem_state_t;

	mem_state_t state;
	logic [CNT_W-1:0] cnt;
	logic done;
	line_t mem_q [NUM_LINES];
	line_t rdata_q;

	// each word starts as its own address scrambled
	initial begin
		for (int n = 0; n < NUM_LINES; n++) begin
			for (int w = 0; w < 4; w++) begin
				mem_q[n][w] = word_t'(4 * n + w) ^ 16'hA5C3;
			end
		end
	end

	assign done = (state == MEM_COUNT) && (cnt == CNT_W'(MEM_LATENCY - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MEM_IDLE;
			cnt <= '0;
		end else if (state == MEM_IDLE) begin
			cnt <= '0;
			if (bus.o_re || bus.o_we) begin
				state <= MEM_COUNT;
			end
		end else if (done) begin
			state <= MEM_IDLE;
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// access completes on the last count cycle
	always @(posedge clk) begin
		if (done) begin
			if (bus.o_we) begin
				mem_q[bus.addr.flat] <= bus.wdata;
			end
			rdata_q <= bus.o_we ? bus.wdata : mem_q[bus.addr.flat];
		end
	end

	assign bus.rdy = (state == MEM_IDLE);
	assign bus.rdata = rdata_q;

	a_req_held: assert property (@(posedge clk) disable iff (rst)
		!bus.rdy |-> (bus.o_re || bus.o_we))
		else $error("memory request dropped while busy");

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
	parameter int MEM_LATENCY = 4
) (
	input logic clk,
	input logic rst,
	input logic [dcache_pkg::ADDR_W-1:0] i_addr,
	input logic i_re,
	input logic i_we,
	input dcache_pkg::word_t i_wdata,
	output dcache_pkg::word_t o_rdata,
	output logic o_hit
);
	import dcache_pkg::*;

	// controller to storage
	index_t way_index;
	logic way_we;
	logic way_sel;
	logic way_valid;
	logic way_dirty;
	tag_t way_tag;
	line_t way_line;
	logic lru_we;
	logic lru_wr;

	// storage to controller
	logic valid0, dirty0, valid1, dirty1;
	tag_t tag0, tag1;
	line_t line0, line1;
	logic lru_rd;

	mem_bus_if u_bus ();

	dcache_ways u_ways (
		.clk(clk),
		.rst(rst),
		.i_index(way_index),
		.i_way_we(way_we),
		.i_way_sel(way_sel),
		.i_valid(way_valid),
		.i_dirty(way_dirty),
		.i_tag(way_tag),
		.i_line(way_line),
		.i_lru_we(lru_we),
		.i_lru(lru_wr),
		.o_valid0(valid0),
		.o_dirty0(dirty0),
		.o_tag0(tag0),
		.o_line0(line0),
		.o_valid1(valid1),
		.o_dirty1(dirty1),
		.o_tag1(tag1),
		.o_line1(line1),
		.o_lru(lru_rd)
	);

	dcache_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.i_addr(i_addr),
		.i_re(i_re),
		.i_we(i_we),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_hit(o_hit),
		.o_index(way_index),
		.o_way_we(way_we),
		.o_way_sel(way_sel),
		.o_valid(way_valid),
		.o_dirty(way_dirty),
		.o_tag(way_tag),
		.o_line(way_line),
		.o_lru_we(lru_we),
		.o_lru(lru_wr),
		.i_valid0(valid0),
		.i_dirty0(dirty0),
		.i_tag0(tag0),
		.i_line0(line0),
		.i_valid1(valid1),
		.i_dirty1(dirty1),
		.i_tag1(tag1),
		.i_line1(line1),
		.i_lru(lru_rd),
		.bus(u_bus.ctrl)
	);

	main_mem #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_mem (
		.clk(clk),
		.rst(rst),
		.bus(u_bus.mem)
	);

endmodule

// File: verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int MAX_ROWS = 64;
	localparam int NUM_RANDOM = 40;
	localparam int HIT_TIMEOUT = 100;

	localparam logic OP_RD = 1'b0;
	localparam logic OP_WR = 1'b1;

	// what the first cycle of a request must show
	localparam logic [1:0] STALL_ANY = 2'd0;
	localparam logic [1:0] STALL_YES = 2'd1;
	localparam logic [1:0] STALL_NO = 2'd2;

	logic clk;
	logic rst;
	logic [ADDR_W-1:0] i_addr;
	logic i_re;
	logic i_we;
	word_t i_wdata;
	word_t o_rdata;
	logic o_hit;

	// stimulus table
	logic tab_op [MAX_ROWS];
	logic [ADDR_W-1:0] tab_addr [MAX_ROWS];
	word_t tab_wdata [MAX_ROWS];
	word_t tab_exp [MAX_ROWS];
	logic tab_chk [MAX_ROWS];
	logic [1:0] tab_stall [MAX_ROWS];
	int num_rows;

	// word-level image of main memory
	word_t shadow [2**ADDR_W];

	int value_errors;
	int other_errors;
	logic timed_out;
	integer seed;

	dcache_top #(
		.MEM_LATENCY(4)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.i_addr(i_addr),
		.i_re(i_re),
		.i_we(i_we),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_hit(o_hit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// memory starts with each word equal to its address scrambled
	function automatic word_t init_word(input logic [ADDR_W-1:0] a);
		return a ^ 16'hA5C3;
	endfunction

	task automatic add_row(input logic op, input logic [ADDR_W-1:0] addr,
			input word_t wdata, input word_t exp, input logic chk, input logic [1:0] stall);
		tab_op[num_rows] = op;
		tab_addr[num_rows] = addr;
		tab_wdata[num_rows] = wdata;
		tab_exp[num_rows] = exp;
		tab_chk[num_rows] = chk;
		tab_stall[num_rows] = stall;
		num_rows++;
	endtask

	task automatic load_table();
		logic [31:0] r_addr;
		logic [31:0] r_op;
		logic [31:0] r_data;
		num_rows = 0;
		// cold miss, repeat hit, then a write into the same line
		add_row(OP_RD, 16'h0010, 16'h0000, init_word(16'h0010), 1'b1, STALL_YES);
		add_row(OP_RD, 16'h0010, 16'h0000, init_word(16'h0010), 1'b1, STALL_NO);
		add_row(OP_WR, 16'h0011, 16'h1234, 16'h0000, 1'b0, STALL_NO);
		add_row(OP_RD, 16'h0011, 16'h0000, 16'h1234, 1'b1, STALL_NO);
		add_row(OP_RD, 16'h0010, 16'h0000, init_word(16'h0010), 1'b1, STALL_NO);
		add_row(OP_RD, 16'h0012, 16'h0000, init_word(16'h0012), 1'b1, STALL_NO);
		add_row(OP_RD, 16'h0013, 16'h0000, init_word(16'h0013), 1'b1, STALL_NO);
		// set 3 with tags 0, 1 and 2
		add_row(OP_WR, 16'h000C, 16'hBEEF, 16'h0000, 1'b0, STALL_YES);
		add_row(OP_RD, 16'h008C, 16'h0000, init_word(16'h008C), 1'b1, STALL_YES);
		add_row(OP_RD, 16'h000C, 16'h0000, 16'hBEEF, 1'b1, STALL_NO);
		add_row(OP_RD, 16'h008C, 16'h0000, init_word(16'h008C), 1'b1, STALL_NO);
		// tag 0 is now least recent and dirty
		add_row(OP_RD, 16'h010C, 16'h0000, init_word(16'h010C), 1'b1, STALL_YES);
		add_row(OP_RD, 16'h008C, 16'h0000, init_word(16'h008C), 1'b1, STALL_NO);
		add_row(OP_RD, 16'h000C, 16'h0000, 16'hBEEF, 1'b1, STALL_YES);
		add_row(OP_RD, 16'h000D, 16'h0000, init_word(16'h000D), 1'b1, STALL_NO);
		add_row(OP_RD, 16'h008C, 16'h0000, init_word(16'h008C), 1'b1, STALL_NO);
		// random traffic over tags 0..3 of sets 0..3
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r_addr = $random(seed);
			r_op = $random(seed);
			r_data = $random(seed);
			add_row(r_op[0], r_addr[15:0] & 16'h018F, r_data[15:0], 16'h0000, 1'b0,
				STALL_ANY);
		end
	endtask

	task automatic apply_row(input int row);
		int waited;
		logic stalled;
		word_t exp;
		@(posedge clk);
		i_addr <= tab_addr[row];
		i_re <= (tab_op[row] == OP_RD);
		i_we <= (tab_op[row] == OP_WR);
		i_wdata <= tab_wdata[row];
		@(negedge clk);
		stalled = !o_hit;
		waited = 0;
		while (o_hit !== 1'b1 && waited < HIT_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (o_hit !== 1'b1) begin
			$display("row %0d timed out waiting for o_hit at address %h", row, tab_addr[row]);
			other_errors++;
			timed_out = 1'b1;
		end else begin
			if (tab_stall[row] == STALL_YES && !stalled) begin
				$display("row %0d at address %h hit at once but should have missed",
					row, tab_addr[row]);
				other_errors++;
			end
			if (tab_stall[row] == STALL_NO && stalled) begin
				$display("row %0d at address %h stalled but should have hit at once",
					row, tab_addr[row]);
				other_errors++;
			end
			if (tab_op[row] == OP_RD) begin
				exp = tab_chk[row] ? tab_exp[row] : shadow[tab_addr[row]];
				if (o_rdata !== exp) begin
					$display("FAILED row %0d i_addr %h: o_rdata got %h expected %h",
						row, tab_addr[row], o_rdata, exp);
					value_errors++;
				end
			end else begin
				shadow[tab_addr[row]] = tab_wdata[row];
				// drop the request since the next cycle is the spin cycle
				@(posedge clk);
				i_re <= 1'b0;
				i_we <= 1'b0;
				@(negedge clk);
				if (o_hit !== 1'b0) begin
					$display("FAILED row %0d spin cycle: o_hit got %h expected %h",
						row, o_hit, 1'b0);
					value_errors++;
				end
			end
		end
	endtask

	initial begin
		seed = 16762;
		rst = 1'b1;
		i_addr = '0;
		i_re = 1'b0;
		i_we = 1'b0;
		i_wdata = '0;
		value_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		for (int a = 0; a < 2**ADDR_W; a++) begin
			shadow[a] = init_word(a[ADDR_W-1:0]);
		end
		load_table();

		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// idle cache reports a hit
		@(negedge clk);
		if (o_hit !== 1'b1) begin
			$display("FAILED after reset: o_hit got %h expected %h", o_hit, 1'b1);
			value_errors++;
		end

		for (int row = 0; row < num_rows && !timed_out; row++) begin
			apply_row(row);
		end

		$display("rows %0d, value errors %0d, other errors %0d",
			num_rows, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: dcache_top.f
verilog/dcache_pkg.sv
verilog/mem_bus_if.sv
verilog/dcache_ways.sv
verilog/dcache_ctrl.sv
verilog/main_mem.sv
verilog/dcache_top.sv
verif/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/mem_bus_if.sv
  - verilog/dcache_ways.sv
  - verilog/dcache_ctrl.sv
  - verilog/main_mem.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - verif/dcache_tb.sv
